// ==== board_pkg.sv ====
`default_nettype none

package board_pkg;

   // =========================================================================
   // Front panel timing and widths
   // =========================================================================

   localparam int PC_WIDTH        = 14;
   localparam int DEBOUNCE_CYCLES = 16;   // Stable clocks before a button counts.
   localparam int STEP_UNIT       = 4;    // Clocks per step-rate unit.
   localparam int SCAN_CYCLES     = 8;    // Clocks each display digit is lit.

   // Taken instead of pc+1 when an interrupt is pending at cycle end.
   localparam logic [PC_WIDTH-1:0] INT_VECTOR = 14'h0040;

   // =========================================================================
   // Panel buses
   // =========================================================================

   // Slide switch configuration.
   typedef struct packed {
      logic [3:0] step_rate;   // Step period, in STEP_UNIT clocks, minus one.
      logic [3:0] boot_page;   // Upper pc bits loaded on boot.
   } panel_cfg_t;

   // Debounced button controls. Boot and interrupt are strobes.
   typedef struct packed {
      logic machine_reset;
      logic boot;
      logic halt;
      logic interrupt;
   } panel_ctl_t;

   // Micro-cycle phases, one-hot, walked in this order.
   typedef enum logic [4:0] {
      S_PREFETCH = 5'b00001,
      S_FETCH    = 5'b00010,
      S_DECODE   = 5'b00100,
      S_EXECUTE  = 5'b01000,
      S_WRITE    = 5'b10000
   } useq_state_t;

endpackage

`default_nettype wire

// ==== panel_support.sv ====
`timescale 1ns/1ps
`default_nettype none

module panel_support (
   input  logic                  clk50,
   input  logic                  reset,
   input  logic [3:0]            button,
   output board_pkg::panel_ctl_t ctl
);
   import board_pkg::*;

   // Button 3 is reset, 2 is boot, 1 is halt toggle, 0 is interrupt.
   logic [3:0] sync_0;
   logic [3:0] sync_1;
   logic [3:0] stable;
   logic [3:0] stable_d;
   logic [3:0] rise;
   logic [$clog2(DEBOUNCE_CYCLES)-1:0] bounce_cnt [4];

   logic       mreset_q;
   logic       boot_q;
   logic       halt_q;
   logic       int_q;

   // Synchronisers and debounce counters.
   always_ff @(posedge clk50)
   begin
      if (reset)
      begin
         sync_0     <= '0;
         sync_1     <= '0;
         stable     <= '0;
         stable_d   <= '0;
         bounce_cnt <= '{default: '0};
      end
      else
      begin
         sync_0   <= button;
         sync_1   <= sync_0;
         stable_d <= stable;
         for (int i = 0; i < 4; i++)
         begin
            if (sync_1[i] == stable[i])
               bounce_cnt[i] <= '0;                // Bounce restarts the count.
            else if (bounce_cnt[i] == DEBOUNCE_CYCLES - 1)
            begin
               stable[i]     <= sync_1[i];
               bounce_cnt[i] <= '0;
            end
            else
               bounce_cnt[i] <= bounce_cnt[i] + 1'b1;
         end
      end
   end

   assign rise = stable & ~stable_d;

   // Panel controls, one clock after the debounced edge.
   always_ff @(posedge clk50)
   begin
      if (reset)
      begin
         mreset_q <= 1'b1;
         boot_q   <= 1'b0;
         halt_q   <= 1'b0;
         int_q    <= 1'b0;
      end
      else
      begin
         mreset_q <= stable[3];                    // Held as long as the button.
         boot_q   <= rise[2];
         int_q    <= rise[0];
         if (stable[3])
            halt_q <= 1'b0;
         else if (rise[1])
            halt_q <= ~halt_q;
      end
   end

   assign ctl = '{machine_reset: mreset_q, boot: boot_q, halt: halt_q, interrupt: int_q};

   a_boot_strobe: assert property (@(posedge clk50) disable iff (reset)
      ctl.boot |=> !ctl.boot)
      else $error("boot strobe held for two cycles");

   a_int_strobe: assert property (@(posedge clk50) disable iff (reset)
      ctl.interrupt |=> !ctl.interrupt)
      else $error("interrupt strobe held for two cycles");

endmodule

`default_nettype wire

// ==== panel_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module panel_regs (
   input  logic                  clk50,
   input  logic                  reset,
   input  logic [7:0]            slideswitch,
   input  logic                  boot,
   output board_pkg::panel_cfg_t cfg
);

   logic [3:0] rate_q;
   logic [3:0] page_q;

   // Step rate tracks the switches live.
   always_ff @(posedge clk50)
   begin
      if (reset)
         rate_q <= '0;
      else
         rate_q <= slideswitch[3:0];
   end

   // Boot page is frozen at boot.
   always_ff @(posedge clk50)
   begin
      if (reset)
         page_q <= '0;
      else if (boot)
         page_q <= slideswitch[7:4];
   end

   assign cfg.step_rate = rate_q;

   // During the strobe the switches pass straight through, so the
   // sequencer loads the new page in the boot cycle itself.
   assign cfg.boot_page = boot ? slideswitch[7:4] : page_q;

endmodule

`default_nettype wire

// ==== step_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_timer (
   input  logic                  clk50,
   input  logic                  reset,
   input  board_pkg::panel_cfg_t cfg,
   output logic                  step
);
   import board_pkg::*;

   // Longest period is 16 rate units.
   logic [$clog2(16 * STEP_UNIT)-1:0] count;
   logic [$clog2(16 * STEP_UNIT)-1:0] reload;
   int unsigned                       period_m1;

   always_comb
   begin
      period_m1 = (cfg.step_rate + 1) * STEP_UNIT - 1;
      reload    = period_m1[$bits(reload)-1:0];
   end

   always_ff @(posedge clk50)
   begin
      if (reset)
      begin
         count <= reload;
         step  <= 1'b0;
      end
      else if (count == '0)
      begin
         count <= reload;                          // Picks up a new rate here.
         step  <= 1'b1;
      end
      else
      begin
         count <= count - 1'b1;
         step  <= 1'b0;
      end
   end

   // Steps stay at least one rate unit apart.
   a_step_spacing: assert property (@(posedge clk50) disable iff (reset)
      step |=> !step [*STEP_UNIT-1])
      else $error("step strobes closer than one rate unit");

endmodule

`default_nettype wire

// ==== micro_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module micro_sequencer (
   input  logic                           clk50,
   input  logic                           reset,
   input  board_pkg::panel_ctl_t          ctl,
   input  logic [3:0]                     boot_page,
   input  logic                           step,
   output logic [board_pkg::PC_WIDTH-1:0] pc,
   output board_pkg::useq_state_t         state,
   output logic                           machrun
);
   import board_pkg::*;

   logic started;       // Set by boot, cleared by machine reset.
   logic int_pending;
   logic advance;
   logic cycle_end;

   assign machrun   = started & ~ctl.halt;
   assign advance   = step & machrun;
   assign cycle_end = advance & (state == S_WRITE);

   always_ff @(posedge clk50)
   begin
      if (reset || ctl.machine_reset)
      begin
         started     <= 1'b0;
         int_pending <= 1'b0;
         state       <= S_PREFETCH;
         pc          <= '0;
      end
      else if (ctl.boot)
      begin
         started     <= 1'b1;
         int_pending <= 1'b0;
         state       <= S_PREFETCH;
         pc          <= {boot_page, {(PC_WIDTH - 4){1'b0}}};
      end
      else
      begin
         if (advance)
            state <= useq_state_t'({state[3:0], state[4]});   // Next phase.

         // =================================================================
         // End of micro-cycle
         // =================================================================
         if (cycle_end)
         begin
            if (int_pending)
               pc <= INT_VECTOR;
            else
               pc <= pc + 1'b1;
         end

         // An interrupt in the taking cycle waits for the next cycle end.
         if (cycle_end)
            int_pending <= ctl.interrupt;
         else if (ctl.interrupt)
            int_pending <= 1'b1;
      end
   end

   a_state_onehot: assert property (@(posedge clk50) disable iff (reset)
      $onehot(state))
      else $error("micro-cycle state not one-hot: %b", state);

endmodule

`default_nettype wire

// ==== hex_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module hex_display (
   input  logic        clk50,
   input  logic        reset,
   input  logic [13:0] pc,
   output logic [7:0]  sevenseg,
   output logic [3:0]  sevenseg_an
);
   import board_pkg::*;

   logic [$clog2(SCAN_CYCLES)-1:0] scan_cnt;
   logic [1:0]                     digit;
   logic [3:0]                     nibble;

   // Segments gfedcba, active low.
   function automatic logic [6:0] hex_segments(input logic [3:0] value);
      case (value)
         4'h0:    hex_segments = 7'b1000000;
         4'h1:    hex_segments = 7'b1111001;
         4'h2:    hex_segments = 7'b0100100;
         4'h3:    hex_segments = 7'b0110000;
         4'h4:    hex_segments = 7'b0011001;
         4'h5:    hex_segments = 7'b0010010;
         4'h6:    hex_segments = 7'b0000010;
         4'h7:    hex_segments = 7'b1111000;
         4'h8:    hex_segments = 7'b0000000;
         4'h9:    hex_segments = 7'b0010000;
         4'ha:    hex_segments = 7'b0001000;
         4'hb:    hex_segments = 7'b0000011;
         4'hc:    hex_segments = 7'b1000110;
         4'hd:    hex_segments = 7'b0100001;
         4'he:    hex_segments = 7'b0000110;
         default: hex_segments = 7'b0001110;
      endcase
   endfunction

   // Digit scan.
   always_ff @(posedge clk50)
   begin
      if (reset)
      begin
         scan_cnt <= '0;
         digit    <= 2'd0;
      end
      else if (scan_cnt == SCAN_CYCLES - 1)
      begin
         scan_cnt <= '0;
         digit    <= digit + 1'b1;
      end
      else
         scan_cnt <= scan_cnt + 1'b1;
   end

   always_comb
   begin
      case (digit)
         2'd0:    nibble = pc[3:0];
         2'd1:    nibble = pc[7:4];
         2'd2:    nibble = pc[11:8];
         default: nibble = {2'b00, pc[13:12]};
      endcase
   end

   // Anode and segments registered together so they stay aligned.
   always_ff @(posedge clk50)
   begin
      sevenseg <= {1'b1, hex_segments(nibble)};   // Dot off.
      if (reset)
         sevenseg_an <= 4'b1110;
      else
         sevenseg_an <= ~(4'b0001 << digit);
   end

   a_one_anode: assert property (@(posedge clk50) disable iff (reset)
      $onehot(~sevenseg_an))
      else $error("anodes not one-hot low: %b", sevenseg_an);

endmodule

`default_nettype wire

// ==== board_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_top (
   input  logic       clk50,
   input  logic       reset,
   input  logic [3:0] button,
   input  logic [7:0] slideswitch,
   output logic [7:0] led,
   output logic [7:0] sevenseg,
   output logic [3:0] sevenseg_an
);
   import board_pkg::*;

   panel_ctl_t          ctl;
   panel_cfg_t          cfg;
   logic                step;
   logic [PC_WIDTH-1:0] pc;
   useq_state_t         state;
   logic                machrun;

   // =========================================================================
   // Front panel
   // =========================================================================

   panel_support support (
      .clk50  (clk50),
      .reset  (reset),
      .button (button),
      .ctl    (ctl)
   );

   panel_regs regs (
      .clk50       (clk50),
      .reset       (reset),
      .slideswitch (slideswitch),
      .boot        (ctl.boot),
      .cfg         (cfg)
   );

   // The reset button also restarts the step prescaler.
   step_timer timer (
      .clk50 (clk50),
      .reset (ctl.machine_reset),
      .cfg   (cfg),
      .step  (step)
   );

   micro_sequencer useq (
      .clk50     (clk50),
      .reset     (reset),
      .ctl       (ctl),
      .boot_page (cfg.boot_page),
      .step      (step),
      .pc        (pc),
      .state     (state),
      .machrun   (machrun)
   );

   hex_display show_pc (
      .clk50       (clk50),
      .reset       (reset),
      .pc          (pc),
      .sevenseg    (sevenseg),
      .sevenseg_an (sevenseg_an)
   );

   assign led[7:3] = state;
   assign led[2]   = machrun;
   assign led[1:0] = 2'b00;                        // Spare.

endmodule

`default_nettype wire

// ==== board_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_tb;
   import board_pkg::*;

   localparam int SETTLE      = 4 * SCAN_CYCLES + 2;   // One full display refresh.
   localparam int MAX_PERIOD  = 16 * STEP_UNIT;
   localparam int PRESS_HOLD  = 3 * DEBOUNCE_CYCLES;
   localparam int RATE_WINDOW = 480;
   // Step budgets of the reset, boot, walk, interrupt, halt and rate tests.
   localparam int STEP_BUDGET = 2 + 10 + 20 + 20 + 30 + 40;
   localparam int RUN_LIMIT   = STEP_BUDGET * MAX_PERIOD + 4 * 3 * PRESS_HOLD;

   logic        clk50;
   logic        reset;
   logic [3:0]  button;
   logic [7:0]  slideswitch;
   logic [7:0]  led;
   logic [7:0]  sevenseg;
   logic [3:0]  sevenseg_an;

   string       cur_test;
   int          errors;
   int          test_start;
   int          tests_run;
   int          tests_failed;
   int unsigned seed;

   // Machine model, kept up to date by the monitor.
   logic [13:0] model_pc;
   logic [3:0]  shown [4];
   logic [13:0] shown_pc;
   logic [3:0]  seen;
   logic [3:0]  prev_an;
   logic [4:0]  prev_state;
   logic        prev_run;
   logic        boot_expected;
   logic [3:0]  boot_page_exp;
   logic        int_expected;
   int          pc_age;
   int          state_changes;
   int          cycle_ends;
   int          seg_val;
   logic [4:0]  hold_state;
   logic [13:0] hold_pc;
   logic [13:0] start_pc;

   board_top dut_i (
      .clk50       (clk50),
      .reset       (reset),
      .button      (button),
      .slideswitch (slideswitch),
      .led         (led),
      .sevenseg    (sevenseg),
      .sevenseg_an (sevenseg_an)
   );

   initial
   begin
      clk50 = 1'b0;
      forever #50 clk50 = ~clk50;
   end

   // =========================================================================
   // Reference functions
   // =========================================================================

   // Dot, then gfedcba, all active low.
   function automatic logic [7:0] seg_pattern(input logic [3:0] n);
      case (n)
         4'h0: return 8'hc0;
         4'h1: return 8'hf9;
         4'h2: return 8'ha4;
         4'h3: return 8'hb0;
         4'h4: return 8'h99;
         4'h5: return 8'h92;
         4'h6: return 8'h82;
         4'h7: return 8'hf8;
         4'h8: return 8'h80;
         4'h9: return 8'h90;
         4'ha: return 8'h88;
         4'hb: return 8'h83;
         4'hc: return 8'hc6;
         4'hd: return 8'ha1;
         4'he: return 8'h86;
         default: return 8'h8e;
      endcase
   endfunction

   function automatic int seg_value(input logic [7:0] seg);
      for (int n = 0; n < 16; n++)
         if (seg_pattern(n[3:0]) === seg)
            return n;
      return -1;                                       // No hex digit.
   endfunction

   function automatic logic [4:0] next_state(input logic [4:0] s);
      case (s)
         S_PREFETCH: return S_FETCH;
         S_FETCH:    return S_DECODE;
         S_DECODE:   return S_EXECUTE;
         S_EXECUTE:  return S_WRITE;
         default:    return S_PREFETCH;
      endcase
   endfunction

   function automatic logic [13:0] boot_pc(input logic [3:0] page);
      return {page, 10'b0};
   endfunction

   // =========================================================================
   // Helpers
   // =========================================================================

   task automatic check_equal(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (expected === actual)
      else
      begin
         $display("mismatch %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
         errors++;
      end
   endtask

   task automatic idle(input int n);
      repeat (n) @(negedge clk50);
      #1;
   endtask

   task automatic set_switches(input logic [7:0] value);
      @(posedge clk50);
      #10 slideswitch = value;
   endtask

   task automatic shake(input int idx);
      int bounces;
      bounces = 1 + $urandom % 6;
      repeat (bounces)
      begin
         @(posedge clk50);
         #10 button[idx] = $urandom % 2;
      end
   endtask

   task automatic press_button(input int idx);
      shake(idx);
      @(posedge clk50);
      #10 button[idx] = 1'b1;
      repeat (PRESS_HOLD) @(posedge clk50);
      shake(idx);
      @(posedge clk50);
      #10 button[idx] = 1'b0;
      repeat (PRESS_HOLD) @(posedge clk50);
   endtask

   // Kind 0 waits for machrun, 1 for cycle ends, 2 for state changes.
   task automatic wait_event(input int kind, input int target, input int limit,
                             input string what);
      int  n;
      bit  done;
      n    = 0;
      done = 1'b0;
      while (!done && n < limit)
      begin
         @(negedge clk50);
         #1;
         n++;
         case (kind)
            0:       done = (led[2] == target[0]);
            1:       done = (cycle_ends >= target);
            default: done = (state_changes >= target);
         endcase
      end
      assert (done)
      else
      begin
         $display("test %s timed out waiting for %s", cur_test, what);
         errors++;
      end
   endtask

   task automatic measure_rate(input int rate);
      int c0;
      int count;
      int expected;
      set_switches({4'h5, rate[3:0]});
      idle(MAX_PERIOD + 2);                            // Let the prescaler reload.
      c0       = state_changes;
      idle(RATE_WINDOW);
      count    = state_changes - c0;
      expected = RATE_WINDOW / ((rate + 1) * STEP_UNIT);
      assert (count >= expected - 1 && count <= expected + 1)
      else
      begin
         $display("mismatch %s rate %0d: expected %0d state changes, actual %0d",
                  cur_test, rate, expected, count);
         errors++;
      end
   endtask

   task automatic start_test(input string name);
      cur_test   = name;
      test_start = errors;
   endtask

   task automatic end_test();
      tests_run++;
      if (errors != test_start)
      begin
         tests_failed++;
         $display("test %s: FAIL (%0d errors)", cur_test, errors - test_start);
      end
      else
         $display("test %s: ok", cur_test);
   endtask

   // =========================================================================
   // Monitor
   // =========================================================================

   always @(negedge clk50)
   begin
      if (!reset)
      begin
         assert ($onehot(~sevenseg_an))
         else
         begin
            $display("test %s: anodes %b are not one-hot low", cur_test, sevenseg_an);
            errors++;
         end
         if (sevenseg_an !== prev_an)
         begin
            check_equal("anode order", {prev_an[2:0], prev_an[3]}, sevenseg_an);
            prev_an = sevenseg_an;
         end
         seg_val = seg_value(sevenseg);
         assert (seg_val >= 0)
         else
         begin
            $display("test %s: segments %h show no hex digit", cur_test, sevenseg);
            errors++;
         end
         for (int d = 0; d < 4; d++)
         begin
            if (!sevenseg_an[d] && seg_val >= 0)
            begin
               shown[d] = seg_val[3:0];
               seen[d]  = 1'b1;
            end
         end
         shown_pc = {shown[3][1:0], shown[2], shown[1], shown[0]};

         pc_age++;
         if (led[7:3] != prev_state)
         begin
            check_equal("next state", next_state(prev_state), led[7:3]);
            state_changes++;
            if (prev_state == S_WRITE)
            begin
               cycle_ends++;
               model_pc     = int_expected ? INT_VECTOR : model_pc + 1'b1;
               int_expected = 1'b0;
               pc_age       = 0;
            end
            prev_state = led[7:3];
         end
         if (led[2] && !prev_run && boot_expected)
         begin
            model_pc      = boot_pc(boot_page_exp);
            boot_expected = 1'b0;
            pc_age        = 0;
         end
         prev_run = led[2];
         if (pc_age == SETTLE && seen == 4'hf)
            check_equal("displayed pc", model_pc, shown_pc);
      end
   end

   initial
   begin
      #(RUN_LIMIT * 100);
      $display("watchdog expired during test %s", cur_test);
      $display("Some tests failed");
      $finish;
   end

   // =========================================================================
   // Test sequence
   // =========================================================================

   initial
   begin
      seed = 32'hdc813b55;
      void'($urandom(seed));
      errors        = 0;
      tests_run     = 0;
      tests_failed  = 0;
      cur_test      = "init";
      model_pc      = '0;
      seen          = '0;
      prev_an       = 4'b1110;                         // Digit 0 lit out of reset.
      prev_state    = S_PREFETCH;
      prev_run      = 1'b0;
      boot_expected = 1'b0;
      boot_page_exp = '0;
      int_expected  = 1'b0;
      pc_age        = 0;
      state_changes = 0;
      cycle_ends    = 0;
      reset         = 1'b1;
      button        = '0;
      slideswitch   = '0;
      repeat (5) @(posedge clk50);
      #10 reset = 1'b0;

      start_test("reset");
      idle(SETTLE);
      check_equal("led", 8'h08, led);
      check_equal("digits seen", 4'hf, seen);
      check_equal("shown pc", 14'h0000, shown_pc);
      end_test();

      start_test("boot");
      set_switches({4'ha, 4'hf});                      // Slowest rate keeps pc still.
      boot_page_exp = 4'ha;
      boot_expected = 1'b1;
      fork
         press_button(2);
         wait_event(0, 1, 2 * PRESS_HOLD, "machrun to rise");
      join
      check_equal("boot taken", 1'b0, boot_expected);
      set_switches({4'h5, 4'hf});
      idle(SETTLE);
      check_equal("shown pc", boot_pc(4'ha), shown_pc);
      end_test();

      start_test("walk");
      set_switches({4'h5, 4'h3});
      wait_event(1, cycle_ends + 1, 8 * MAX_PERIOD, "a micro-cycle end");
      start_pc = model_pc;
      wait_event(2, state_changes + 10, 12 * MAX_PERIOD, "ten state changes");
      idle(SETTLE);
      check_equal("shown pc", start_pc + 14'd2, shown_pc);
      end_test();

      start_test("interrupt");
      wait_event(1, cycle_ends + 1, 6 * MAX_PERIOD, "a micro-cycle end");
      int_expected = 1'b1;
      press_button(0);
      check_equal("interrupt taken", 1'b0, int_expected);
      idle(SETTLE);
      check_equal("shown pc", INT_VECTOR, shown_pc);
      wait_event(1, cycle_ends + 1, 6 * MAX_PERIOD, "a micro-cycle end");
      idle(SETTLE);
      check_equal("shown pc", INT_VECTOR + 14'd1, shown_pc);
      end_test();

      start_test("halt");
      press_button(1);
      wait_event(0, 0, MAX_PERIOD, "machrun to fall");
      hold_state = led[7:3];
      hold_pc    = model_pc;
      idle(20 * 4 * STEP_UNIT);                        // 20 step periods at rate 3.
      check_equal("held state", hold_state, led[7:3]);
      check_equal("held pc", hold_pc, shown_pc);
      fork
         press_button(1);
         begin
            wait_event(0, 1, 2 * PRESS_HOLD, "machrun to rise");
            check_equal("resumed state", hold_state, led[7:3]);
            check_equal("resumed pc", hold_pc, shown_pc);
         end
      join
      end_test();

      start_test("step rate");
      measure_rate(0);
      measure_rate(5);
      end_test();

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== all.f ====
board_pkg.sv
panel_support.sv
panel_regs.sv
step_timer.sv
micro_sequencer.sv
hex_display.sv
board_top.sv
board_tb.sv
